/* dv/ts_monitor_tb.sv */
`timescale 1ns/1ps

module ts_monitor_tb import ts_monitor_pkg::*; ();

	typedef struct packed {
		logic [12:0] cfg_pid;
		logic enable;
		logic [12:0] stream_pid;
		logic [1:0] npkt;
		logic clear;
		logic [7:0] cut;
		logic exp_ready;
		logic [15:0] exp_pkts;
		logic [15:0] exp_ovr;
	} row_t;

	logic mpeg_clk;
	logic S_AXI_ARESETN;
	logic [7:0] mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic [axi_addr_width-1:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [data_width-1:0] s_axi_wdata;
	logic [3:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [axi_addr_width-1:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [data_width-1:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;

	row_t rows [0:8];
	logic [7:0] pkt [0:pack_byte_size-1];
	logic [7:0] win [0:pack_byte_size-1];
	logic model_ready;
	logic model_bank;
	logic captured_any;
	int errors;
	int checks;

	ts_monitor_top dut0 (.*);

	initial begin
		mpeg_clk = 1'b0;
		forever #5 mpeg_clk = ~mpeg_clk;
	end

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// ==========================================================================
	// AXI4-Lite master
	// ==========================================================================
	task automatic axi_write(input logic [axi_addr_width-1:0] addr, input logic [31:0] data);
		int t;
		@(negedge mpeg_clk);
		s_axi_awaddr = addr;
		s_axi_awvalid = 1'b1;
		s_axi_wdata = data;
		s_axi_wstrb = 4'hf;
		s_axi_wvalid = 1'b1;
		t = 0;
		while (!(s_axi_awready && s_axi_wready)) begin
			@(negedge mpeg_clk);
			t++;
			if (t > 50)
				stop_on_timeout("no awready/wready on a register write");
		end
		@(negedge mpeg_clk);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b1;
		t = 0;
		while (!s_axi_bvalid) begin
			@(negedge mpeg_clk);
			t++;
			if (t > 50)
				stop_on_timeout("no write response");
		end
		check_value("BRESP", 32'(s_axi_bresp), 32'd0);
		@(negedge mpeg_clk);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [axi_addr_width-1:0] addr, output logic [31:0] data);
		int t;
		@(negedge mpeg_clk);
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		t = 0;
		while (!s_axi_arready) begin
			@(negedge mpeg_clk);
			t++;
			if (t > 50)
				stop_on_timeout("no arready on a register read");
		end
		@(negedge mpeg_clk);
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b1;
		t = 0;
		while (!s_axi_rvalid) begin
			@(negedge mpeg_clk);
			t++;
			if (t > 50)
				stop_on_timeout("no read data");
		end
		data = s_axi_rdata;
		check_value("RRESP", 32'(s_axi_rresp), 32'd0);
		@(negedge mpeg_clk);
		s_axi_rready = 1'b0;
	endtask

	// ==========================================================================
	// Packet generator
	// ==========================================================================
	task automatic build_packet(input logic [12:0] pid);
		int i;
		pkt[0] = sync_byte;
		// Error, start and priority flags sit above the PID.
		pkt[1] = {3'($urandom), pid[12:8]};
		pkt[2] = pid[7:0];
		for (i = 3; i < pack_byte_size; i++)
			pkt[i] = 8'($urandom);
	endtask

	task automatic send_bytes(input int count);
		int i;
		int gap;
		for (i = 0; i < count; i++) begin
			gap = ($urandom % 4 == 0) ? int'($urandom % 3) + 1 : 0;
			repeat (gap) begin
				@(negedge mpeg_clk);
				mpeg_valid = 1'b0;
				mpeg_sync = 1'b0;
				mpeg_data = 8'($urandom);
			end
			@(negedge mpeg_clk);
			mpeg_valid = 1'b1;
			mpeg_sync = (i == 0);
			mpeg_data = pkt[i];
		end
		@(negedge mpeg_clk);
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
	endtask

	task automatic compare_window();
		logic [31:0] got;
		int w;
		for (w = 0; w < pack_word_size; w++) begin
			axi_read(reg_window + 9'(4 * w), got);
			check_value($sformatf("window word %0d", w), got,
				{win[4*w+3], win[4*w+2], win[4*w+1], win[4*w]});
		end
	endtask

	task automatic load_table();
		// cfg PID, enable, stream PID, packets, clear, cut bytes, ready, count, overrun.
		rows[0] = '{13'h00a5, 1'b0, 13'h00a5, 2'd1, 1'b0, 8'd0, 1'b0, 16'd0, 16'd0};
		rows[1] = '{13'h00a5, 1'b1, 13'h00a4, 2'd1, 1'b0, 8'd0, 1'b0, 16'd0, 16'd0};
		rows[2] = '{13'h00a5, 1'b1, 13'h00a5, 2'd1, 1'b0, 8'd0, 1'b1, 16'd1, 16'd0};
		rows[3] = '{13'h00a5, 1'b1, 13'h00a5, 2'd1, 1'b0, 8'd0, 1'b1, 16'd1, 16'd1};
		rows[4] = '{13'h00a5, 1'b1, 13'h0123, 2'd1, 1'b0, 8'd0, 1'b1, 16'd1, 16'd1};
		rows[5] = '{13'h1a5c, 1'b1, 13'h1a5c, 2'd1, 1'b1, 8'd0, 1'b1, 16'd2, 16'd1};
		rows[6] = '{13'h1a5c, 1'b1, 13'h1a5c, 2'd1, 1'b1, 8'd60, 1'b1, 16'd3, 16'd1};
		rows[7] = '{13'h1a5c, 1'b0, 13'h1a5c, 2'd1, 1'b1, 8'd0, 1'b0, 16'd3, 16'd1};
		rows[8] = '{13'h00a5, 1'b1, 13'h00a5, 2'd2, 1'b0, 8'd0, 1'b1, 16'd4, 16'd2};
	endtask

	initial begin
		row_t row;
		int r;
		int p;
		int i;
		int errs_before;
		int tries;
		logic [31:0] st;
		logic [31:0] ov;

		void'($urandom(32'h80ab_66b9));
		S_AXI_ARESETN = 1'b0;
		mpeg_data = 8'd0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = 4'h0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		model_ready = 1'b0;
		model_bank = 1'b0;
		captured_any = 1'b0;
		errors = 0;
		checks = 0;
		load_table();

		repeat (16) @(posedge mpeg_clk);
		@(negedge mpeg_clk);
		S_AXI_ARESETN = 1'b1;

		axi_read(reg_ctrl, st);
		check_value("CTRL after reset", st, 32'd0);
		axi_read(reg_pid, st);
		check_value("PID after reset", st, 32'd0);
		axi_read(reg_status, st);
		check_value("STATUS after reset", st, 32'd0);
		axi_read(reg_overrun, st);
		check_value("OVERRUN after reset", st, 32'd0);
		$display("reset values: %0d error(s)", errors);

		for (r = 0; r < 9; r++) begin
			row = rows[r];
			errs_before = errors;
			axi_write(reg_ctrl, {31'd0, row.enable});
			axi_write(reg_pid, {19'd0, row.cfg_pid});
			if (row.clear) begin
				axi_write(reg_status, 32'h1);
				model_ready = 1'b0;
			end
			// Truncated packet, abandoned by the next header.
			if (row.cut != 8'd0) begin
				build_packet(row.stream_pid);
				send_bytes(int'(row.cut));
			end
			for (p = 0; p < int'(row.npkt); p++) begin
				build_packet(row.stream_pid);
				send_bytes(pack_byte_size);
				if (row.enable && row.stream_pid == row.cfg_pid && !model_ready) begin
					for (i = 0; i < pack_byte_size; i++)
						win[i] = pkt[i];
					model_ready = 1'b1;
					model_bank = ~model_bank;
					captured_any = 1'b1;
				end
			end

			repeat (8) @(negedge mpeg_clk);
			axi_read(reg_status, st);
			if (row.exp_ready) begin
				tries = 0;
				while (!st[0]) begin
					tries++;
					if (tries > 20)
						stop_on_timeout("ready flag never rose");
					axi_read(reg_status, st);
				end
			end
			check_value("STATUS", st, {row.exp_pkts, 14'd0, model_bank, row.exp_ready});
			axi_read(reg_overrun, ov);
			check_value("OVERRUN", ov, {16'd0, row.exp_ovr});
			if (captured_any)
				compare_window();
			$display("row %0d: %0d packet(s) of PID %h, %0d error(s)", r, row.npkt,
				row.stream_pid, errors - errs_before);
		end

		$display("Summary: %0d rows, %0d checks, %0d errors", 9, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* list.f */
verilog/ts_monitor_pkg.sv
verilog/ts_packet_buffer.sv
verilog/ts_packet_capture.sv
verilog/ts_axil_regs.sv
verilog/ts_monitor_top.sv
dv/ts_monitor_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module ts_monitor_tb -f list.f -o ts_monitor_sim &&
	./obj_dir/ts_monitor_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "TEST FAILED" sim.log && exit 1
grep -qs "TEST OK" sim.log || exit 1

/* verilog/ts_axil_regs.sv */
`timescale 1ns/1ps

module ts_axil_regs import ts_monitor_pkg::*; (
	input  logic                      mpeg_clk,
	input  logic                      S_AXI_ARESETN,
	input  logic [axi_addr_width-1:0] s_axi_awaddr,
	input  logic                      s_axi_awvalid,
	output logic                      s_axi_awready,
	input  logic [data_width-1:0]     s_axi_wdata,
	input  logic [3:0]                s_axi_wstrb,
	input  logic                      s_axi_wvalid,
	output logic                      s_axi_wready,
	output logic [1:0]                s_axi_bresp,
	output logic                      s_axi_bvalid,
	input  logic                      s_axi_bready,
	input  logic [axi_addr_width-1:0] s_axi_araddr,
	input  logic                      s_axi_arvalid,
	output logic                      s_axi_arready,
	output logic [data_width-1:0]     s_axi_rdata,
	output logic [1:0]                s_axi_rresp,
	output logic                      s_axi_rvalid,
	input  logic                      s_axi_rready,
	output capture_cfg_t              cfg,
	input  capture_status_t           status,
	output logic                      rd_en,
	output logic [5:0]                rd_word,
	input  logic [data_width-1:0]     rd_data
);

	logic aw_take;
	logic wr_fire;
	logic ar_take;
	logic ar_fire;
	logic rd_s1;
	logic rd_s2;
	logic [axi_addr_width-1:0] waddr;
	logic [axi_addr_width-1:0] ar_addr_q;
	logic [data_width-1:0] rd_mux;

	function automatic logic is_window(input logic [axi_addr_width-1:0] a);
		return (a >= reg_window) && (a < reg_window + axi_addr_width'(pack_byte_size));
	endfunction

	assign s_axi_bresp = 2'b00;
	assign s_axi_rresp = 2'b00;

	// ==========================================================================
	// Write channel
	// ==========================================================================
	assign aw_take = s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
	assign wr_fire = s_axi_awvalid && s_axi_awready && s_axi_wvalid && s_axi_wready;
	assign waddr = {s_axi_awaddr[axi_addr_width-1:2], 2'b00};

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			s_axi_awready <= 1'b0;
			s_axi_wready <= 1'b0;
			s_axi_bvalid <= 1'b0;
			cfg <= '0;
		end
		else begin
			s_axi_awready <= aw_take;
			s_axi_wready <= aw_take;
			cfg.clear_ready <= 1'b0;
			if (wr_fire) begin
				s_axi_bvalid <= 1'b1;
				case (waddr)
					reg_ctrl: begin
						if (s_axi_wstrb[0])
							cfg.enable <= s_axi_wdata[0];
					end
					reg_pid: begin
						if (s_axi_wstrb[0])
							cfg.pid[7:0] <= s_axi_wdata[7:0];
						if (s_axi_wstrb[1])
							cfg.pid[12:8] <= s_axi_wdata[12:8];
					end
					// Write one to clear the sticky ready flag.
					reg_status: begin
						if (s_axi_wstrb[0] && s_axi_wdata[0])
							cfg.clear_ready <= 1'b1;
					end
					default: begin
					end
				endcase
			end
			else if (s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
		end
	end

	// ==========================================================================
	// Read channel, two cycles from address to data
	// ==========================================================================
	assign ar_take = s_axi_arvalid && !s_axi_arready && !rd_s1 && !rd_s2 && !s_axi_rvalid;
	assign ar_fire = s_axi_arvalid && s_axi_arready;

	always_comb begin
		if (is_window(ar_addr_q)) begin
			rd_mux = rd_data;
		end
		else begin
			case ({ar_addr_q[axi_addr_width-1:2], 2'b00})
				reg_ctrl: rd_mux = data_width'(cfg.enable);
				reg_pid: rd_mux = data_width'(cfg.pid);
				reg_status: rd_mux = {status.packet_count, 14'd0, status.read_bank,
					status.ready};
				reg_overrun: rd_mux = data_width'(status.overrun_count);
				default: rd_mux = '0;
			endcase
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid <= 1'b0;
			rd_s1 <= 1'b0;
			rd_s2 <= 1'b0;
			rd_en <= 1'b0;
		end
		else begin
			s_axi_arready <= ar_take;
			rd_s1 <= ar_fire;
			rd_en <= ar_fire && is_window(s_axi_araddr);
			rd_s2 <= rd_s1;
			if (rd_s2)
				s_axi_rvalid <= 1'b1;
			else if (s_axi_rready)
				s_axi_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (ar_fire) begin
			ar_addr_q <= s_axi_araddr;
			rd_word <= s_axi_araddr[7:2];
		end
		if (rd_s2)
			s_axi_rdata <= rd_mux;
	end

	a_rvalid_hold: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

	// A pending response also blocks the next write address.
	a_bvalid_hold: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && !s_axi_awready);

endmodule

/* verilog/ts_monitor_pkg.sv */
package ts_monitor_pkg;

	// ==========================================================================
	// Stream and buffer geometry
	// ==========================================================================
	localparam int pack_byte_size = 188;
	localparam int data_width = 32;
	localparam int pack_word_size = pack_byte_size / (data_width / 8);
	localparam int axi_addr_width = 9;

	localparam logic [7:0] sync_byte = 8'h47;

	// ==========================================================================
	// Register map, byte offsets
	// ==========================================================================
	localparam logic [axi_addr_width-1:0] reg_ctrl = 9'h000;
	localparam logic [axi_addr_width-1:0] reg_pid = 9'h004;
	localparam logic [axi_addr_width-1:0] reg_status = 9'h008;
	localparam logic [axi_addr_width-1:0] reg_overrun = 9'h00C;
	// Packet window runs from here for one packet, last word at 0x1B8.
	localparam logic [axi_addr_width-1:0] reg_window = 9'h100;

	typedef struct packed {
		logic [7:0] data;
		logic sync;
		logic valid;
	} ts_byte_t;

	typedef struct packed {
		logic enable;
		logic [12:0] pid;
		logic clear_ready;
	} capture_cfg_t;

	typedef struct packed {
		logic ready;
		logic read_bank;
		logic [15:0] packet_count;
		logic [15:0] overrun_count;
	} capture_status_t;

	typedef struct packed {
		logic en;
		logic bank;
		logic [5:0] word;
		logic [1:0] lane;
		logic [7:0] data;
	} buf_wr_t;

endpackage

/* verilog/ts_monitor_top.sv */
`timescale 1ns/1ps

module ts_monitor_top import ts_monitor_pkg::*; (
	input  logic                      mpeg_clk,
	input  logic                      S_AXI_ARESETN,
	input  logic [7:0]                mpeg_data,
	input  logic                      mpeg_valid,
	input  logic                      mpeg_sync,
	input  logic [axi_addr_width-1:0] s_axi_awaddr,
	input  logic                      s_axi_awvalid,
	output logic                      s_axi_awready,
	input  logic [data_width-1:0]     s_axi_wdata,
	input  logic [3:0]                s_axi_wstrb,
	input  logic                      s_axi_wvalid,
	output logic                      s_axi_wready,
	output logic [1:0]                s_axi_bresp,
	output logic                      s_axi_bvalid,
	input  logic                      s_axi_bready,
	input  logic [axi_addr_width-1:0] s_axi_araddr,
	input  logic                      s_axi_arvalid,
	output logic                      s_axi_arready,
	output logic [data_width-1:0]     s_axi_rdata,
	output logic [1:0]                s_axi_rresp,
	output logic                      s_axi_rvalid,
	input  logic                      s_axi_rready
);

	ts_byte_t stream;
	capture_cfg_t cfg;
	capture_status_t status;
	buf_wr_t buf_wr;
	logic rd_en;
	logic [5:0] rd_word;
	logic [data_width-1:0] rd_data;

	assign stream = '{data: mpeg_data, sync: mpeg_sync, valid: mpeg_valid};

	ts_axil_regs u_regs (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.cfg           (cfg),
		.status        (status),
		.rd_en         (rd_en),
		.rd_word       (rd_word),
		.rd_data       (rd_data)
	);

	ts_packet_capture u_capture (
		.mpeg_clk      (mpeg_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.stream        (stream),
		.cfg           (cfg),
		.status        (status),
		.wr            (buf_wr)
	);

	// Software always reads the bank the engine handed over last.
	ts_packet_buffer u_buffer (
		.mpeg_clk (mpeg_clk),
		.wr       (buf_wr),
		.rd_en    (rd_en),
		.rd_bank  (status.read_bank),
		.rd_word  (rd_word),
		.rd_data  (rd_data)
	);

endmodule

/* verilog/ts_packet_buffer.sv */
`timescale 1ns/1ps

module ts_packet_buffer import ts_monitor_pkg::*; (
	input  logic                  mpeg_clk,
	input  buf_wr_t               wr,
	input  logic                  rd_en,
	input  logic                  rd_bank,
	input  logic [5:0]            rd_word,
	output logic [data_width-1:0] rd_data
);

	logic [data_width-1:0] mem0 [0:pack_word_size-1];
	logic [data_width-1:0] mem1 [0:pack_word_size-1];

	// Single byte lane per write, byte 0 of a word in the low lane.
	always_ff @(posedge mpeg_clk) begin
		if (wr.en && !wr.bank)
			mem0[wr.word][{wr.lane, 3'b000} +: 8] <= wr.data;
		if (wr.en && wr.bank)
			mem1[wr.word][{wr.lane, 3'b000} +: 8] <= wr.data;
	end

	always_ff @(posedge mpeg_clk) begin
		if (rd_en) begin
			if (rd_bank)
				rd_data <= mem1[rd_word];
			else
				rd_data <= mem0[rd_word];
		end
	end

	// ==========================================================================
	// Index bounds from the capture engine and the register block
	// ==========================================================================
	a_wr_word: assert property (@(posedge mpeg_clk)
		wr.en |-> wr.word < 6'(pack_word_size));

	a_rd_word: assert property (@(posedge mpeg_clk)
		rd_en |-> rd_word < 6'(pack_word_size));

endmodule

/* verilog/ts_packet_capture.sv */
`timescale 1ns/1ps

module ts_packet_capture import ts_monitor_pkg::*; (
	input  logic            mpeg_clk,
	input  logic            S_AXI_ARESETN,
	input  ts_byte_t        stream,
	input  capture_cfg_t    cfg,
	output capture_status_t status,
	output buf_wr_t         wr
);

	ts_byte_t dly [0:2];
	logic active;
	logic [1:0] pend;
	logic [7:0] widx;
	logic [7:0] acc;
	logic [12:0] hdr_pid;
	logic [7:0] wr_byte;
	logic hdr;
	logic hit;
	logic take;
	logic done;
	logic ready_eff;
	logic ready_n;
	logic flip;
	logic rb_next;
	logic last_issue;

	always_comb begin
		// Sync byte in stage 2, PID high bits in stage 1, PID low byte arriving now.
		hdr_pid = {dly[0].data[4:0], stream.data};
		hdr = stream.valid && dly[1].sync && (dly[1].data == sync_byte);
		hit = hdr && cfg.enable && (hdr_pid == cfg.pid);
		take = stream.valid && active && (acc < 8'(pack_byte_size));
		done = wr.en && (wr.word == 6'(pack_word_size - 1)) && (wr.lane == 2'd3);
		ready_eff = status.ready && !cfg.clear_ready;
		ready_n = ready_eff || done;
		flip = done && !ready_eff;
		rb_next = flip ? wr.bank : status.read_bank;
		last_issue = (pend != 2'd0) && (widx == 8'(pack_byte_size - 1));
		// Oldest unwritten byte sits pend-1 stages deep.
		case (pend)
			2'd1: wr_byte = dly[0].data;
			2'd2: wr_byte = dly[1].data;
			default: wr_byte = dly[2].data;
		endcase
	end

	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			dly[0] <= '0;
			dly[1] <= '0;
			dly[2] <= '0;
		end
		else if (stream.valid) begin
			dly[0] <= stream;
			dly[1] <= dly[0];
			dly[2] <= dly[1];
		end
	end

	// ==========================================================================
	// Byte placement and packet hand-off
	// ==========================================================================
	always_ff @(posedge mpeg_clk) begin
		if (!S_AXI_ARESETN) begin
			active <= 1'b0;
			pend <= 2'd0;
			widx <= 8'd0;
			acc <= 8'd0;
			wr <= '0;
			status <= '0;
		end
		else begin
			wr <= '{en: pend != 2'd0, bank: ~rb_next, word: widx[7:2],
				lane: widx[1:0], data: wr_byte};
			if (pend != 2'd0)
				widx <= widx + 8'd1;
			if (take)
				acc <= acc + 8'd1;
			// Any accepted byte shifts the line, taken or not.
			case ({pend != 2'd0, stream.valid, take})
				3'b100: pend <= pend - 2'd1;
				3'b011: pend <= pend + 2'd1;
				default: pend <= pend;
			endcase
			if (last_issue) begin
				active <= 1'b0;
				pend <= 2'd0;
			end

			// A new header always drops whatever partial packet is in flight.
			if (hdr) begin
				active <= hit && !ready_n;
				pend <= (hit && !ready_n) ? 2'd3 : 2'd0;
				acc <= 8'd3;
				widx <= 8'd0;
			end

			if (flip) begin
				status.ready <= 1'b1;
				status.read_bank <= wr.bank;
				status.packet_count <= status.packet_count + 16'd1;
			end
			else if (cfg.clear_ready) begin
				status.ready <= 1'b0;
			end
			status.overrun_count <= status.overrun_count + 16'(done && ready_eff)
				+ 16'(hit && ready_n);
		end
	end

	a_idx_range: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		active |-> widx <= 8'(pack_byte_size - 1));

	// The bank handed to software stays put until ready is cleared.
	a_bank_guard: assert property (@(posedge mpeg_clk) disable iff (!S_AXI_ARESETN)
		status.ready && !cfg.clear_ready |=> status.ready && $stable(status.read_bank));

endmodule
